// ==== Makefile ====
# Verilator build and run for the SPI slave register block

SIM       := verilator
SIM_FLAGS := --binary --timing -j 0
TOP       := spi_slave_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	rm -f $(LOG)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
src/spi_slave_pkg.sv
src/spi_slave_io.sv
src/spi_slave_regs.sv
src/spi_slave.sv
test/spi_clock_gen.sv
test/spi_slave_tb.sv

// ==== src/spi_slave.sv ====
// top level of the SPI slave register block, pin engine plus register file on one clock
`timescale 1ns/1ps

module spi_slave #(
   parameter int ureg_count = 13,   // user registers, 1 to 32
   parameter int aw         = 32,   // packet address and data width
   parameter int pw         = 104   // mesh packet width
)
(
   input  logic          clk,
   input  logic          nreset,
   // spi pins
   input  logic          sclk,
   input  logic          mosi,
   input  logic          ss_n,
   output logic          miso,
   // core side
   input  logic          hw_en,
   input  logic          access_in,
   input  logic [pw-1:0] packet_in,
   input  logic          access_out,
   output logic          irq,
   output logic [511:0]  reg_vector
);

   logic [5:0] reg_addr;
   logic [7:0] reg_wdata;
   logic       reg_write;
   logic [7:0] reg_rdata;
   logic       spi_en;
   logic       cpol;
   logic       cpha;
   logic       lsbfirst;

   //################################################
   // pin engine
   //################################################
   spi_slave_io u_io (
      .clk       (clk),
      .nreset    (nreset),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .spi_en    (spi_en),
      .cpol      (cpol),
      .cpha      (cpha),
      .lsbfirst  (lsbfirst),
      .reg_rdata (reg_rdata),
      .miso      (miso),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_write (reg_write)
   );

   //################################################
   // register file
   //################################################
   spi_slave_regs #(
      .ureg_count (ureg_count),
      .aw         (aw),
      .pw         (pw)
   ) u_regs (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_write  (reg_write),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .access_out (access_out),
      .reg_rdata  (reg_rdata),
      .spi_en     (spi_en),
      .cpol       (cpol),
      .cpha       (cpha),
      .lsbfirst   (lsbfirst),
      .irq        (irq),
      .reg_vector (reg_vector)
   );

endmodule

// ==== src/spi_slave_io.sv ====
// SPI pin engine: synchronizes the pins, shifts bytes, decodes command and address for the register file
`timescale 1ns/1ps

module spi_slave_io
   import spi_slave_pkg::*;
(
   input  logic       clk,
   input  logic       nreset,
   input  logic       sclk,        // async spi clock pin
   input  logic       mosi,
   input  logic       ss_n,
   input  logic       spi_en,      // from config, latched per frame
   input  logic       cpol,
   input  logic       cpha,
   input  logic       lsbfirst,
   input  logic [7:0] reg_rdata,   // comb lookup of reg_addr
   output logic       miso,
   output logic [5:0] reg_addr,
   output logic [7:0] reg_wdata,
   output logic       reg_write    // one cycle strobe
);

   logic [1:0] sclk_sync;
   logic [1:0] mosi_sync;
   logic [1:0] ss_sync;
   logic       sclk_s;
   logic       mosi_s;
   logic       ss_s;
   logic       sclk_q;             // previous synced sclk
   logic       ss_q;
   logic       ss_fall;

   logic       frame_act;          // inside a frame with the link enabled
   logic       lat_cpol;
   logic       lat_cpha;
   logic       lat_lsb;

   logic       sclk_rise;
   logic       sclk_fall;
   logic       lead_edge;
   logic       trail_edge;
   logic       sample_edge;
   logic       shift_edge;

   logic [2:0] bit_cnt;
   logic [7:0] rx_shift;
   logic [7:0] rx_next;
   logic       cmd_phase;          // first byte of the frame still coming
   logic [1:0] cmd_op;
   logic       byte_done;          // data byte finished, bump address
   logic       load_tx;
   logic       tx_fresh;           // skip the first shift edge after a load
   logic [7:0] tx_shift;

   //################################################
   // pin synchronizers and edge detect
   //################################################
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         sclk_sync <= 2'b00;
         mosi_sync <= 2'b00;
         ss_sync   <= 2'b11;       // deselected
         sclk_q    <= 1'b0;
         ss_q      <= 1'b1;
      end
      else
      begin
         sclk_sync <= {sclk_sync[0], sclk};
         mosi_sync <= {mosi_sync[0], mosi};
         ss_sync   <= {ss_sync[0], ss_n};
         sclk_q    <= sclk_s;
         ss_q      <= ss_s;
      end
   end

   assign sclk_s    = sclk_sync[1];
   assign mosi_s    = mosi_sync[1];
   assign ss_s      = ss_sync[1];
   assign ss_fall   = ss_q & ~ss_s;
   assign sclk_rise = sclk_s & ~sclk_q;
   assign sclk_fall = sclk_q & ~sclk_s;

   // leading edge leaves the idle level
   assign lead_edge   = lat_cpol ? sclk_fall : sclk_rise;
   assign trail_edge  = lat_cpol ? sclk_rise : sclk_fall;
   assign sample_edge = frame_act & ~ss_s & (lat_cpha ? trail_edge : lead_edge);
   assign shift_edge  = frame_act & ~ss_s & (lat_cpha ? lead_edge : trail_edge);

   // mode and enable frozen for the whole frame
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         frame_act <= 1'b0;
         lat_cpol  <= 1'b0;
         lat_cpha  <= 1'b0;
         lat_lsb   <= 1'b0;
      end
      else if (ss_fall)
      begin
         frame_act <= spi_en;
         lat_cpol  <= cpol;
         lat_cpha  <= cpha;
         lat_lsb   <= lsbfirst;
      end
      else if (ss_s)
         frame_act <= 1'b0;        // frame over
   end

   //################################################
   // receive side, byte count and command decode
   //################################################
   assign rx_next = lat_lsb ? {mosi_s, rx_shift[7:1]} : {rx_shift[6:0], mosi_s};

   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         bit_cnt   <= 3'd0;
         cmd_phase <= 1'b1;
         cmd_op    <= 2'b00;
         reg_addr  <= 6'd0;
         reg_write <= 1'b0;
         byte_done <= 1'b0;
         load_tx   <= 1'b0;
      end
      else
      begin
         reg_write <= 1'b0;        // strobes default low
         byte_done <= 1'b0;
         load_tx   <= 1'b0;
         if (ss_fall)
         begin
            bit_cnt   <= 3'd0;
            cmd_phase <= 1'b1;
         end
         else if (sample_edge)
         begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
            begin
               if (cmd_phase)
               begin
                  cmd_phase <= 1'b0;
                  cmd_op    <= rx_next[7:6];
                  reg_addr  <= rx_next[5:0];   // start address
                  load_tx   <= (rx_next[7:6] == cmd_read);
               end
               else
               begin
                  byte_done <= 1'b1;
                  reg_write <= (cmd_op == cmd_write);
               end
            end
         end
         // address moves one cycle after the write strobe, wraps at 63
         if (byte_done)
         begin
            reg_addr <= reg_addr + 6'd1;
            load_tx  <= (cmd_op == cmd_read);
         end
      end
   end

   // shifter and write data carry no reset
   always_ff @(posedge clk)
   begin
      if (sample_edge)
         rx_shift <= rx_next;
      if (sample_edge && bit_cnt == 3'd7 && !cmd_phase)
         reg_wdata <= rx_next;     // complete data byte
   end

   //################################################
   // transmit side
   //################################################
   always_ff @(posedge clk)
   begin
      if (!nreset)
      begin
         tx_shift <= 8'd0;
         tx_fresh <= 1'b0;
      end
      else if (ss_fall)
      begin
         tx_shift <= 8'd0;         // zeros while the command comes in
         tx_fresh <= 1'b0;
      end
      else if (load_tx)
      begin
         tx_shift <= reg_rdata;    // first bit shows right away
         tx_fresh <= 1'b1;
      end
      else if (shift_edge)
      begin
         if (tx_fresh)
            tx_fresh <= 1'b0;      // this edge presents bit 0, keep it
         else if (lat_lsb)
            tx_shift <= {1'b0, tx_shift[7:1]};
         else
            tx_shift <= {tx_shift[6:0], 1'b0};
      end
   end

   assign miso = frame_act & ~ss_s & (lat_lsb ? tx_shift[0] : tx_shift[7]);

endmodule

// ==== src/spi_slave_pkg.sv ====
// register map, command and packet constants shared by the SPI slave RTL and its testbench
package spi_slave_pkg;

   //################################################
   // register map (6-bit byte addresses)
   //################################################
   localparam logic [5:0] addr_config    = 6'd0;   // config byte, rw
   localparam logic [5:0] addr_status    = 6'd1;   // data ready status, ro
   localparam logic [5:0] addr_core_base = 6'd16;  // 8 core receive bytes, ro
   localparam logic [5:0] addr_user_base = 6'd32;  // user register bank, rw

   localparam int core_bytes = 8;   // data then srcaddr, lsb first
   localparam int user_max   = 32;  // upper limit for ureg_count

   //################################################
   // command byte, opcode in [7:6], start addr in [5:0]
   //################################################
   localparam logic [1:0] cmd_write = 2'b00;
   localparam logic [1:0] cmd_read  = 2'b10;

   // config byte bit positions
   localparam int cfg_disable  = 0;  // kill the link until reset
   localparam int cfg_irq_en   = 1;
   localparam int cfg_cpol     = 2;
   localparam int cfg_cpha     = 3;
   localparam int cfg_lsbfirst = 4;

   //################################################
   // mesh packet fields, 104 bits with aw = 32
   //################################################
   localparam int pkt_write        = 0;   // single bit
   localparam int pkt_datamode_lsb = 1;   // bits 2:1
   localparam int pkt_datamode_w   = 2;
   localparam int pkt_ctrlmode_lsb = 3;   // bits 7:3
   localparam int pkt_ctrlmode_w   = 5;
   localparam int pkt_dstaddr_lsb  = 8;   // aw bits from here on
   localparam int pkt_data_lsb     = 40;
   localparam int pkt_srcaddr_lsb  = 72;

endpackage

// ==== src/spi_slave_regs.sv ====
// SPI slave register file: config, status, core receive bytes and user registers with readback
`timescale 1ns/1ps

module spi_slave_regs
   import spi_slave_pkg::*;
#(
   parameter int ureg_count = 13,   // user registers, 1 to 32
   parameter int aw         = 32,   // address and data width
   parameter int pw         = 104   // packet width
)
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          hw_en,        // block enable pin
   input  logic [5:0]    reg_addr,
   input  logic [7:0]    reg_wdata,
   input  logic          reg_write,
   input  logic          access_in,    // packet strobe from core
   input  logic [pw-1:0] packet_in,
   input  logic          access_out,   // clears data ready
   output logic [7:0]    reg_rdata,
   output logic          spi_en,
   output logic          cpol,
   output logic          cpha,
   output logic          lsbfirst,
   output logic          irq,
   output logic [511:0]  reg_vector    // byte n at [8n+7:8n]
);

   logic [7:0]      config_reg;
   logic [7:0]      status_reg;
   logic [2*aw-1:0] core_reg;          // srcaddr over data
   logic [2*aw-1:0] core_data;
   logic            config_write;
   logic [7:0]      ureg_bytes [user_max];

   //################################################
   // config byte
   //################################################
   assign config_write = reg_write & (reg_addr == addr_config);

   always_ff @(posedge clk)
   begin
      if (!nreset)
         config_reg <= 8'd0;
      else if (config_write)
         config_reg <= reg_wdata;
   end

   assign spi_en   = hw_en & ~config_reg[cfg_disable];   // security kill
   assign cpol     = config_reg[cfg_cpol];
   assign cpha     = config_reg[cfg_cpha];
   assign lsbfirst = config_reg[cfg_lsbfirst];

   //################################################
   // status and core receive field
   //################################################
   always_ff @(posedge clk)
   begin
      if (!nreset)
         status_reg <= 8'd0;
      else if (access_out)
         status_reg <= 8'd0;       // clear wins over set
      else if (access_in)
         status_reg <= 8'd1;       // data ready
   end

   // keep data and source address of the packet
   assign core_data = {packet_in[pkt_srcaddr_lsb +: aw], packet_in[pkt_data_lsb +: aw]};

   always_ff @(posedge clk)
   begin
      if (!nreset)
         core_reg <= '0;
      else if (access_in)
         core_reg <= core_data;
   end

   assign irq = config_reg[cfg_irq_en] & status_reg[0];

   //################################################
   // user register bank
   //################################################
   for (genvar i = 0; i < user_max; i++)
   begin : g_ureg
      if (i < ureg_count)
      begin : g_live
         logic user_write;
         assign user_write = reg_write & (reg_addr == addr_user_base + 6'(i));

         always_ff @(posedge clk)
         begin
            if (!nreset)
               ureg_bytes[i] <= 8'd0;
            else if (user_write)
               ureg_bytes[i] <= reg_wdata;
         end
      end
      else
      begin : g_none
         assign ureg_bytes[i] = 8'd0;   // write dropped, reads zero
      end
   end

   //################################################
   // register vector and readback
   //################################################
   always_comb
   begin
      reg_vector = '0;             // reserved bytes read zero
      reg_vector[8*addr_config +: 8] = config_reg;
      reg_vector[8*addr_status +: 8] = status_reg;
      reg_vector[8*addr_core_base +: 8*core_bytes] = core_reg;
      for (int j = 0; j < user_max; j++)
         reg_vector[8*addr_user_base + 8*j +: 8] = ureg_bytes[j];
   end

   // byte lane select
   assign reg_rdata = reg_vector[{reg_addr, 3'b000} +: 8];

endmodule

// ==== test/spi_clock_gen.sv ====
// testbench clock and reset source, 10 ns clock with a two cycle low reset that can be restarted
`timescale 1ns/1ps

module spi_clock_gen (
   input  logic reset_req,   // high for a cycle restarts the reset pulse
   output logic clk,
   output logic nreset
);

   logic clk_q   = 1'b0;
   logic rst_q   = 1'b0;     // starts in reset
   logic armed   = 1'b0;     // first reset cycle seen

   always #5 clk_q = ~clk_q;   // 10 ns period

   // nreset sampled low on two rising edges
   always @(posedge clk_q)
   begin
      if (reset_req)
      begin
         armed <= 1'b0;
         rst_q <= 1'b0;
      end
      else if (!armed)
         armed <= 1'b1;
      else
         rst_q <= 1'b1;        // release
   end

   assign clk    = clk_q;
   assign nreset = rst_q;

endmodule

// ==== test/spi_slave_tb.sv ====
// directed testbench for the SPI slave register block, runs SPI frames and core strobes against a model
`timescale 1ns/1ps

module spi_slave_tb
   import spi_slave_pkg::*;
();

   localparam int pw          = 104;
   localparam int ureg_count  = 13;
   localparam int half_clks   = 5;     // sclk half period in clk cycles
   localparam int wait_limit  = 50;    // cycles before a wait gives up
   localparam int cfg_addr    = int'(addr_config);
   localparam int status_addr = int'(addr_status);
   localparam int core_base   = int'(addr_core_base);
   localparam int user_base   = int'(addr_user_base);

   logic          clk;
   logic          nreset;
   logic          reset_req;
   logic          sclk;
   logic          mosi;
   logic          ss_n;
   logic          hw_en;
   logic          access_in;
   logic [pw-1:0] packet_in;
   logic          access_out;
   logic          miso;
   logic          irq;
   logic [511:0]  reg_vector;

   logic [7:0] model  [64];     // expected register bytes
   logic [7:0] tx_buf [72];     // byte 0 is the command
   logic [7:0] rx_buf [72];
   logic       cur_pol;         // mode the master uses now
   logic       cur_pha;
   logic       cur_lsb;
   logic       hw_on;           // hw_en as last driven
   int         error_count;
   int         timeout_count;

   spi_clock_gen u_clk (
      .reset_req (reset_req),
      .clk       (clk),
      .nreset    (nreset)
   );

   spi_slave #(
      .ureg_count (ureg_count),
      .aw         (32),
      .pw         (pw)
   ) uut (
      .clk        (clk),
      .nreset     (nreset),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss_n       (ss_n),
      .miso       (miso),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .access_out (access_out),
      .irq        (irq),
      .reg_vector (reg_vector)
   );

   //################################################
   // register model
   //################################################
   task automatic clear_model();
      for (int n = 0; n < 64; n++)
         model[n] = 8'd0;
      follow_config();
   endtask

   // mode bits apply from the next frame on
   task automatic follow_config();
      cur_pol = model[cfg_addr][cfg_cpol];
      cur_pha = model[cfg_addr][cfg_cpha];
      cur_lsb = model[cfg_addr][cfg_lsbfirst];
   endtask

   // only config and live user bytes take writes
   task automatic model_write(input int addr, input logic [7:0] data);
      if (addr == cfg_addr)
         model[addr] = data;
      else if (addr >= user_base && addr < user_base + ureg_count)
         model[addr] = data;
   endtask

   function automatic logic expected_irq();
      return model[cfg_addr][cfg_irq_en] & model[status_addr][0];
   endfunction

   function automatic logic [pw-1:0] random_packet();
      logic [pw-1:0] pkt;
      pkt[31:0]   = $urandom;
      pkt[63:32]  = $urandom;
      pkt[95:64]  = $urandom;
      pkt[103:96] = 8'($urandom);
      return pkt;
   endfunction

   //################################################
   // SPI master
   //################################################
   task automatic half_period(output logic seen);
      repeat (half_clks - 1) @(posedge clk);
      @(negedge clk);
      seen = miso;               // settled since the last shift
      @(posedge clk);
   endtask

   task automatic spi_frame(input int nbytes);
      logic seen;
      int   idx;
      @(posedge clk);
      sclk <= cur_pol;           // idle level while deselected
      half_period(seen);
      ss_n <= 1'b0;
      half_period(seen);
      for (int i = 0; i < nbytes; i++)
      begin
         rx_buf[i] = 8'd0;
         for (int b = 0; b < 8; b++)
         begin
            idx = cur_lsb ? b : 7 - b;
            if (!cur_pha)
            begin
               mosi <= tx_buf[i][idx];
               half_period(seen);      // miso before the leading edge
               rx_buf[i][idx] = seen;
               sclk <= ~cur_pol;       // leading, both sides sample
               half_period(seen);
               sclk <= cur_pol;        // trailing, both sides shift
            end
            else
            begin
               sclk <= ~cur_pol;       // leading edge shifts
               mosi <= tx_buf[i][idx];
               half_period(seen);
               rx_buf[i][idx] = seen;
               sclk <= cur_pol;        // trailing edge samples
               half_period(seen);
            end
         end
      end
      if (!cur_pha)
         half_period(seen);
      ss_n <= 1'b1;
      mosi <= 1'b0;
      half_period(seen);         // deselect gap
   endtask

   // a dead link must keep miso low for the whole frame
   task automatic check_quiet(input int nbytes);
      for (int i = 0; i < nbytes; i++)
         if (rx_buf[i] !== 8'd0)
         begin
            error_count++;
            $display("ERROR %0t: miso active on a disabled link, byte %0d is %02h",
                     $time, i, rx_buf[i]);
         end
   endtask

   // data bytes go in tx_buf[1..nbytes] before the call
   task automatic spi_write(input int start, input int nbytes);
      logic link_up;
      link_up = hw_on & ~model[cfg_addr][cfg_disable];
      tx_buf[0] = {cmd_write, 6'(start)};
      spi_frame(nbytes + 1);
      if (link_up)
         for (int i = 0; i < nbytes; i++)
            model_write((start + i) % 64, tx_buf[i + 1]);
      else
         check_quiet(nbytes + 1);
      follow_config();
   endtask

   task automatic spi_read_check(input int start, input int nbytes);
      logic       link_up;
      logic [7:0] expect_byte;
      int         addr;
      link_up = hw_on & ~model[cfg_addr][cfg_disable];
      tx_buf[0] = {cmd_read, 6'(start)};
      for (int i = 0; i < nbytes; i++)
         tx_buf[i + 1] = 8'd0;
      spi_frame(nbytes + 1);
      if (!link_up)
         check_quiet(nbytes + 1);
      for (int i = 0; i < nbytes; i++)
      begin
         addr        = (start + i) % 64;      // wraps at 63
         expect_byte = link_up ? model[addr] : 8'd0;
         if (rx_buf[i + 1] !== expect_byte)
         begin
            error_count++;
            $display("ERROR %0t: read addr %0d got %02h expected %02h",
                     $time, addr, rx_buf[i + 1], expect_byte);
         end
      end
   endtask

   //################################################
   // core side and checks
   //################################################
   task automatic core_strobe(input logic load, input logic clear, input logic [pw-1:0] pkt);
      @(posedge clk);
      access_in  <= load;
      access_out <= clear;
      packet_in  <= pkt;
      @(posedge clk);
      access_in  <= 1'b0;
      access_out <= 1'b0;
      if (load)
         for (int k = 0; k < 4; k++)
         begin
            model[core_base + k]     = pkt[pkt_data_lsb + 8*k +: 8];
            model[core_base + 4 + k] = pkt[pkt_srcaddr_lsb + 8*k +: 8];
         end
      if (clear)
         model[status_addr] = 8'd0;   // clear beats set
      else if (load)
         model[status_addr] = 8'd1;
   endtask

   task automatic set_hw_en(input logic value);
      @(posedge clk);
      hw_en <= value;
      hw_on = value;
   endtask

   task automatic check_vector();
      @(negedge clk);
      for (int n = 0; n < 64; n++)
         if (reg_vector[8*n +: 8] !== model[n])
         begin
            error_count++;
            $display("ERROR %0t: reg_vector byte %0d is %02h, expected %02h",
                     $time, n, reg_vector[8*n +: 8], model[n]);
         end
   endtask

   task automatic wait_irq(input logic value);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (irq !== value && cycles < wait_limit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (irq !== value)
      begin
         timeout_count++;
         $display("irq did not reach %0b within %0d cycles at %0t", value, wait_limit, $time);
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (nreset !== 1'b1 && cycles < wait_limit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (nreset !== 1'b1)
      begin
         timeout_count++;
         $display("reset never released within %0d cycles", wait_limit);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset_req <= 1'b1;
      @(posedge clk);
      reset_req <= 1'b0;
      wait_reset_release();
      clear_model();             // everything back to zero
   endtask

   //################################################
   // directed tests
   //################################################
   task automatic test_reset_state();
      spi_read_check(0, 64);
      @(negedge clk);
      if (irq !== 1'b0)
      begin
         error_count++;
         $display("ERROR %0t: irq high after reset", $time);
      end
      if (reg_vector !== '0)
      begin
         error_count++;
         $display("ERROR %0t: reg_vector not zero after reset", $time);
      end
   endtask

   task automatic test_user_regs();
      for (int i = 0; i < 16; i++)
         tx_buf[i + 1] = 8'($urandom);
      spi_write(user_base, 16);        // last three land past the bank
      spi_read_check(user_base, 16);
      for (int i = 0; i < 14; i++)
         tx_buf[i + 1] = 8'($urandom);
      spi_write(2, 14);                // reserved gap 2 to 15
      spi_read_check(2, 14);
      check_vector();
   endtask

   task automatic test_core_packet();
      core_strobe(1'b1, 1'b0, random_packet());
      spi_read_check(0, 24);           // status and both core fields
      wait_irq(expected_irq());        // irq_en still off
      tx_buf[1] = 8'(1 << cfg_irq_en);
      spi_write(cfg_addr, 1);
      wait_irq(expected_irq());
      core_strobe(1'b0, 1'b1, '0);
      wait_irq(expected_irq());
      spi_read_check(status_addr, 1);
      core_strobe(1'b1, 1'b0, random_packet());
      wait_irq(expected_irq());
      core_strobe(1'b1, 1'b1, random_packet());   // both in one cycle
      wait_irq(expected_irq());
      spi_read_check(0, 24);
      check_vector();
   endtask

   task automatic test_modes();
      logic [7:0] cfg;
      for (int l = 0; l < 2; l++)
         for (int m = 0; m < 4; m++)
         begin
            cfg               = 8'd0;
            cfg[cfg_cpol]     = m[1];
            cfg[cfg_cpha]     = m[0];
            cfg[cfg_lsbfirst] = l[0];
            tx_buf[1] = cfg;
            for (int i = 1; i <= user_base; i++)
               tx_buf[i + 1] = 8'($urandom);   // status, reserved and core drop these
            spi_write(cfg_addr, user_base + 1);   // old mode up to the first user byte
            for (int i = 0; i < 4; i++)
               tx_buf[i + 1] = 8'($urandom);
            spi_write(user_base + 2*m + l, 4);
            spi_read_check(cfg_addr, 1);
            spi_read_check(user_base, ureg_count);
         end
      tx_buf[1] = 8'd0;                // back to mode 0, msb first
      spi_write(cfg_addr, 1);
      check_vector();
   endtask

   task automatic test_disable();
      set_hw_en(1'b0);
      for (int i = 0; i < 4; i++)
         tx_buf[i + 1] = 8'($urandom);
      spi_write(user_base, 4);         // dropped
      check_vector();
      spi_read_check(user_base, 4);
      set_hw_en(1'b1);
      spi_read_check(user_base, ureg_count);
      for (int i = 0; i < 4; i++)
         tx_buf[i + 1] = 8'($urandom);
      spi_write(user_base, 4);
      spi_read_check(user_base, 4);
      tx_buf[1] = 8'(1 << cfg_disable);
      spi_write(cfg_addr, 1);          // link dead until reset
      for (int i = 0; i < 4; i++)
         tx_buf[i + 1] = 8'($urandom);
      spi_write(user_base, 4);
      spi_read_check(0, 64);
      check_vector();
      apply_reset();
      test_reset_state();
   endtask

   //################################################
   // main sequence
   //################################################
   initial
   begin
      void'($urandom(32'h61c145fa));
      error_count   = 0;
      timeout_count = 0;
      reset_req     = 1'b0;
      sclk          = 1'b0;
      mosi          = 1'b0;
      ss_n          = 1'b1;
      hw_en         = 1'b1;
      hw_on         = 1'b1;
      access_in     = 1'b0;
      access_out    = 1'b0;
      packet_in     = '0;
      clear_model();
      wait_reset_release();
      test_reset_state();
      test_user_regs();
      test_core_packet();
      test_modes();
      test_disable();
      $display("errors: %0d  timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule
